// File: source/alu_pkg.sv
package alu_pkg;

    // width of every operand, register and result in the slice
    localparam int DATA_W = 8;

    // opcode numbering follows the hobby CPU op table, so the
    // unused rows (shifts, divide, BCD) leave gaps in the encoding
    typedef enum logic [4:0] {
        OP_A      = 5'd0,
        OP_B      = 5'd1,
        OP_ZERO   = 5'd2,
        OP_NEG_A  = 5'd3,
        OP_NEG_B  = 5'd4,
        OP_A_INC  = 5'd5,
        OP_B_INC  = 5'd6,
        OP_A_DEC  = 5'd7,
        OP_B_DEC  = 5'd8,
        OP_ADD    = 5'd9,
        OP_SUB    = 5'd10,
        OP_MUL_HI = 5'd16,
        OP_MUL_LO = 5'd17,
        OP_AND    = 5'd25,
        OP_OR     = 5'd26
    } alu_op_e;

    // pass_x turns any operation into OP_A, x_zero replaces x with zero
    typedef struct packed {
        alu_op_e op;
        logic    pass_x;
        logic    x_zero;
    } alu_ctrl_t;

    // true for the opcodes the ALU implements
    function automatic logic op_defined(alu_op_e op);
        case (op)
            OP_A, OP_B, OP_ZERO, OP_NEG_A, OP_NEG_B,
            OP_A_INC, OP_B_INC, OP_A_DEC, OP_B_DEC,
            OP_ADD, OP_SUB, OP_MUL_HI, OP_MUL_LO,
            OP_AND, OP_OR: return 1'b1;
            default:       return 1'b0;
        endcase
    endfunction

endpackage

// File: source/dp_pkg.sv
package dp_pkg;

    // the instruction format has room for four registers only
    localparam int NUM_REGS = 4;
    localparam int IDX_W    = $clog2(NUM_REGS);

    typedef logic [IDX_W-1:0] reg_idx_t;

    // instruction word as it arrives with the strobe, 22 bits
    typedef struct packed {
        alu_pkg::alu_ctrl_t          ctrl;
        reg_idx_t                    dst;
        reg_idx_t                    src_x;
        reg_idx_t                    src_y;
        // take y from imm instead of the register file
        logic                        y_imm_sel;
        logic [alu_pkg::DATA_W-1:0]  imm;
    } instr_t;

    // operation handed from the input side to the ALU and writeback.
    // x and y are already resolved to values
    typedef struct packed {
        logic                        valid;
        alu_pkg::alu_ctrl_t          ctrl;
        reg_idx_t                    dst;
        logic [alu_pkg::DATA_W-1:0]  x;
        logic [alu_pkg::DATA_W-1:0]  y;
    } exec_t;

endpackage

// File: source/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        instr_strobe,
    input  dp_pkg::instr_t              instr,
    output dp_pkg::reg_idx_t            rd_x_idx,
    output dp_pkg::reg_idx_t            rd_y_idx,
    input  logic [alu_pkg::DATA_W-1:0]  rd_x_data,
    input  logic [alu_pkg::DATA_W-1:0]  rd_y_data,
    output dp_pkg::exec_t               exec
);

    // first stage holds the strobed instruction while its operands are read
    dp_pkg::instr_t              instr_q;
    logic                        instr_vld_q;

    // second stage is the resolved operation seen by the ALU
    logic                        exec_vld_q;
    alu_pkg::alu_ctrl_t          ctrl_q;
    dp_pkg::reg_idx_t            dst_q;
    logic [alu_pkg::DATA_W-1:0]  x_q;
    logic [alu_pkg::DATA_W-1:0]  y_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_vld_q <= 1'b0;
            exec_vld_q  <= 1'b0;
        end else begin
            instr_vld_q <= instr_strobe;
            exec_vld_q  <= instr_vld_q;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_strobe) begin
            instr_q <= instr;
        end
        if (instr_vld_q) begin
            ctrl_q <= instr_q.ctrl;
            dst_q  <= instr_q.dst;
            x_q    <= rd_x_data;
            // immediate replaces the second register operand when selected
            y_q    <= instr_q.y_imm_sel ? instr_q.imm : rd_y_data;
        end
    end

    // registers are read one cycle after the strobe, before the write of
    // the instruction strobed just ahead of this one
    assign rd_x_idx = instr_q.src_x;
    assign rd_y_idx = instr_q.src_y;

    assign exec = '{valid: exec_vld_q, ctrl: ctrl_q, dst: dst_q, x: x_q, y: y_q};

    // only implemented opcodes may be issued into the slice
    a_strobed_op_defined: assert property (
        @(posedge clk) disable iff (!arst_n)
        instr_strobe |-> alu_pkg::op_defined(instr.ctrl.op)
    ) else $error("instr_decoder: undefined opcode %0h strobed", instr.ctrl.op);

endmodule

// File: source/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                        clk,
    input  logic                        arst_n,
    input  dp_pkg::reg_idx_t            rd_x_idx,
    input  dp_pkg::reg_idx_t            rd_y_idx,
    output logic [alu_pkg::DATA_W-1:0]  rd_x_data,
    output logic [alu_pkg::DATA_W-1:0]  rd_y_data,
    input  logic                        wr_en,
    input  dp_pkg::reg_idx_t            wr_idx,
    input  logic [alu_pkg::DATA_W-1:0]  wr_data
);

    logic [alu_pkg::DATA_W-1:0] regs [dp_pkg::NUM_REGS];

    // the instruction set has no way to initialise a register other than
    // writing it, so all of them start out as zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < dp_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // read ports are plain muxes, with no bypass of a write in flight.
    // a write lands on the same edge where the reader two slots behind
    // starts its read, so no forwarding is needed
    assign rd_x_data = regs[rd_x_idx];
    assign rd_y_data = regs[rd_y_idx];

    // an X written back here would poison every later instruction
    a_wr_data_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr_en |-> !$isunknown(wr_data)
    ) else $error("reg_file: unknown write data to r%0d", wr_idx);

endmodule

// File: source/alu.sv
`timescale 1ns/10ps

module alu (
    input  alu_pkg::alu_ctrl_t          ctrl,
    input  logic                        active,
    input  logic [alu_pkg::DATA_W-1:0]  x,
    input  logic [alu_pkg::DATA_W-1:0]  y,
    input  logic                        cin_n,
    output logic [alu_pkg::DATA_W-1:0]  res,
    output logic                        cout_n
);

    // one extra bit on top carries the carry or borrow of the operation
    typedef logic [alu_pkg::DATA_W:0] ext_t;

    alu_pkg::alu_op_e                  op_eff;
    logic [alu_pkg::DATA_W-1:0]        x_eff;
    logic                              cin;
    logic [2*alu_pkg::DATA_W-1:0]      prod;
    ext_t                              res_ext;
    logic                              op_known;

    // overrides gate the inputs before anything else sees them
    assign op_eff = ctrl.pass_x ? alu_pkg::OP_A : ctrl.op;
    assign x_eff  = ctrl.x_zero ? '0 : x;

    // carry flag is kept active low, as on the rest of the CPU
    assign cin = ~cin_n;

    assign prod = x_eff * y;

    always_comb begin
        op_known = 1'b1;
        case (op_eff)
            alu_pkg::OP_A:      res_ext = {1'b0, x_eff};
            alu_pkg::OP_B:      res_ext = {1'b0, y};
            alu_pkg::OP_ZERO:   res_ext = '0;
            // negation borrows whenever the operand is nonzero
            alu_pkg::OP_NEG_A:  res_ext = ext_t'(0) - {1'b0, x_eff};
            alu_pkg::OP_NEG_B:  res_ext = ext_t'(0) - {1'b0, y};
            alu_pkg::OP_A_INC:  res_ext = {1'b0, x_eff} + ext_t'(1);
            alu_pkg::OP_B_INC:  res_ext = {1'b0, y} + ext_t'(1);
            alu_pkg::OP_A_DEC:  res_ext = {1'b0, x_eff} - ext_t'(1);
            alu_pkg::OP_B_DEC:  res_ext = {1'b0, y} - ext_t'(1);
            // only the add and subtract rows consume the incoming carry
            alu_pkg::OP_ADD:    res_ext = {1'b0, x_eff} + {1'b0, y} + ext_t'(cin);
            alu_pkg::OP_SUB:    res_ext = {1'b0, x_eff} - {1'b0, y} - ext_t'(cin);
            alu_pkg::OP_MUL_HI: res_ext = {1'b0, prod[2*alu_pkg::DATA_W-1:alu_pkg::DATA_W]};
            alu_pkg::OP_MUL_LO: res_ext = {1'b0, prod[alu_pkg::DATA_W-1:0]};
            alu_pkg::OP_AND:    res_ext = {1'b0, x_eff & y};
            alu_pkg::OP_OR:     res_ext = {1'b0, x_eff | y};
            default: begin
                // unimplemented rows read as zero with no carry
                res_ext  = '0;
                op_known = 1'b0;
            end
        endcase
    end

    assign res    = res_ext[alu_pkg::DATA_W-1:0];
    assign cout_n = ~res_ext[alu_pkg::DATA_W];

    // the ALU is combinational, so the check is deferred until the inputs
    // coming from the decoder stage have settled in the time step
    always_comb begin
        if (active) begin
            a_op_defined: assert final (op_known)
                else $error("alu: undefined opcode %0h executed", op_eff);
        end
    end

endmodule

// File: source/result_writeback.sv
`timescale 1ns/10ps

module result_writeback (
    input  logic                        clk,
    input  logic                        arst_n,
    input  dp_pkg::exec_t               exec,
    input  logic [alu_pkg::DATA_W-1:0]  res,
    input  logic                        cout_n,
    output logic                        wr_en,
    output dp_pkg::reg_idx_t            wr_idx,
    output logic [alu_pkg::DATA_W-1:0]  wr_data,
    output logic                        cin_n,
    output logic [alu_pkg::DATA_W-1:0]  result,
    output logic                        carry_n,
    output logic                        result_valid
);

    logic [alu_pkg::DATA_W-1:0]  result_q;
    logic                        carry_n_q;
    logic                        result_vld_q;

    // carry_n_q resets high, which means no carry pending
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_q     <= '0;
            carry_n_q    <= 1'b1;
            result_vld_q <= 1'b0;
        end else begin
            result_vld_q <= exec.valid;
            if (exec.valid) begin
                result_q  <= res;
                // logic and pass rows already report no carry from the ALU
                carry_n_q <= cout_n;
            end
        end
    end

    // register file write shares the edge with the result register
    assign wr_en   = exec.valid;
    assign wr_idx  = exec.dst;
    assign wr_data = res;

    // the flag updated by one operation is the carry-in of the next one
    assign cin_n = carry_n_q;

    assign result       = result_q;
    assign carry_n      = carry_n_q;
    assign result_valid = result_vld_q;

endmodule

// File: source/alu_datapath.sv
`timescale 1ns/10ps

module alu_datapath (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        instr_strobe,
    input  dp_pkg::instr_t              instr,
    output logic [alu_pkg::DATA_W-1:0]  result,
    output logic                        carry_n,
    output logic                        result_valid
);

    dp_pkg::reg_idx_t            rd_x_idx;
    dp_pkg::reg_idx_t            rd_y_idx;
    logic [alu_pkg::DATA_W-1:0]  rd_x_data;
    logic [alu_pkg::DATA_W-1:0]  rd_y_data;
    dp_pkg::exec_t               exec;
    logic [alu_pkg::DATA_W-1:0]  alu_res;
    logic                        alu_cout_n;
    logic                        cin_n;
    logic                        wr_en;
    dp_pkg::reg_idx_t            wr_idx;
    logic [alu_pkg::DATA_W-1:0]  wr_data;

    // strobe at edge E0, operands read after E0, exec registered at E0+1,
    // result and register write at E0+2
    instr_decoder u_instr_decoder (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_strobe (instr_strobe),
        .instr        (instr),
        .rd_x_idx     (rd_x_idx),
        .rd_y_idx     (rd_y_idx),
        .rd_x_data    (rd_x_data),
        .rd_y_data    (rd_y_data),
        .exec         (exec)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_x_idx  (rd_x_idx),
        .rd_y_idx  (rd_y_idx),
        .rd_x_data (rd_x_data),
        .rd_y_data (rd_y_data),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data)
    );

    alu u_alu (
        .ctrl   (exec.ctrl),
        .active (exec.valid),
        .x      (exec.x),
        .y      (exec.y),
        .cin_n  (cin_n),
        .res    (alu_res),
        .cout_n (alu_cout_n)
    );

    result_writeback u_result_writeback (
        .clk          (clk),
        .arst_n       (arst_n),
        .exec         (exec),
        .res          (alu_res),
        .cout_n       (alu_cout_n),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .cin_n        (cin_n),
        .result       (result),
        .carry_n      (carry_n),
        .result_valid (result_valid)
    );

endmodule

// File: sim/tb_alu_datapath.sv
`timescale 1ns/10ps

module tb_alu_datapath;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 5;
    localparam int RANDOM_INSTR   = 200;
    // instructions issued by the directed tests 1 to 5
    localparam int DIRECTED_INSTR = 37;
    localparam int TOTAL_INSTR    = DIRECTED_INSTR + RANDOM_INSTR;
    localparam int WATCHDOG_NS    = (TOTAL_INSTR + 20) * 2 * CLK_PERIOD;

    typedef logic [alu_pkg::DATA_W-1:0] data_t;

    typedef struct packed {
        data_t result;
        logic  carry_n;
    } alu_out_t;

    // expected values of one instruction and the edge its result must follow
    typedef struct packed {
        alu_out_t    exp;
        logic [31:0] edge_no;
    } expect_t;

    // a register write of the model that has not reached the register file yet
    typedef struct packed {
        logic             valid;
        dp_pkg::reg_idx_t idx;
        data_t            data;
    } pend_wr_t;

    logic           clk;
    logic           arst_n;
    logic           instr_strobe;
    dp_pkg::instr_t instr;
    data_t          result;
    logic           carry_n;
    logic           result_valid;

    integer      seed = 66;
    int          errors = 0;
    int          checks = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [31:0] cycle_cnt = '0;

    data_t    shadow_regs [dp_pkg::NUM_REGS];
    logic     shadow_carry_n;
    pend_wr_t pend1;
    pend_wr_t pend2;
    expect_t  exp_q [$];

    alu_pkg::alu_op_e op_list [15] = '{
        alu_pkg::OP_A, alu_pkg::OP_B, alu_pkg::OP_ZERO, alu_pkg::OP_NEG_A,
        alu_pkg::OP_NEG_B, alu_pkg::OP_A_INC, alu_pkg::OP_B_INC, alu_pkg::OP_A_DEC,
        alu_pkg::OP_B_DEC, alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_MUL_HI,
        alu_pkg::OP_MUL_LO, alu_pkg::OP_AND, alu_pkg::OP_OR
    };

    alu_datapath u_alu_datapath (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_strobe (instr_strobe),
        .instr        (instr),
        .result       (result),
        .carry_n      (carry_n),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // expected ALU behavior; a 16-bit form holds the 9-bit result, bit 8 is the carry
    function automatic alu_out_t ref_alu(alu_pkg::alu_op_e op, logic pass_x, logic x_zero,
                                         data_t x, data_t y, logic carry_n_in);
        alu_pkg::alu_op_e eff_op;
        logic [15:0]      xv;
        logic [15:0]      yv;
        logic [15:0]      cv;
        logic [15:0]      prod;
        logic [15:0]      wide;
        alu_out_t         out;
        eff_op = pass_x ? alu_pkg::OP_A : op;
        xv     = x_zero ? 16'h0000 : {8'h00, x};
        yv     = {8'h00, y};
        cv     = {15'h0000, ~carry_n_in};
        prod   = xv * yv;
        case (eff_op)
            alu_pkg::OP_A:      wide = xv;
            alu_pkg::OP_B:      wide = yv;
            alu_pkg::OP_ZERO:   wide = 16'h0000;
            alu_pkg::OP_NEG_A:  wide = 16'h0000 - xv;
            alu_pkg::OP_NEG_B:  wide = 16'h0000 - yv;
            alu_pkg::OP_A_INC:  wide = xv + 16'h0001;
            alu_pkg::OP_B_INC:  wide = yv + 16'h0001;
            alu_pkg::OP_A_DEC:  wide = xv - 16'h0001;
            alu_pkg::OP_B_DEC:  wide = yv - 16'h0001;
            alu_pkg::OP_ADD:    wide = xv + yv + cv;
            alu_pkg::OP_SUB:    wide = xv - yv - cv;
            alu_pkg::OP_MUL_HI: wide = {8'h00, prod[15:8]};
            alu_pkg::OP_MUL_LO: wide = {8'h00, prod[7:0]};
            alu_pkg::OP_AND:    wide = xv & yv;
            alu_pkg::OP_OR:     wide = xv | yv;
            default:            wide = 16'h0000;
        endcase
        out.result  = wide[7:0];
        out.carry_n = ~wide[8];
        return out;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic dp_pkg::instr_t make_instr(alu_pkg::alu_op_e op, dp_pkg::reg_idx_t dst,
                                                  dp_pkg::reg_idx_t sx, dp_pkg::reg_idx_t sy,
                                                  logic imm_sel, data_t imm);
        dp_pkg::instr_t ins;
        ins           = '0;
        ins.ctrl.op   = op;
        ins.dst       = dst;
        ins.src_x     = sx;
        ins.src_y     = sy;
        ins.y_imm_sel = imm_sel;
        ins.imm       = imm;
        return ins;
    endfunction

    // one clock cycle of stimulus, with the model advanced in step with the DUT
    task automatic step(input logic strobe, input dp_pkg::instr_t ins);
        data_t   x_val;
        data_t   y_val;
        expect_t item;
        @(negedge clk);
        // the write of the instruction two slots back has landed by now
        if (pend2.valid) begin
            shadow_regs[pend2.idx] = pend2.data;
        end
        pend2 = pend1;
        pend1 = '0;
        if (strobe) begin
            x_val = shadow_regs[ins.src_x];
            y_val = ins.y_imm_sel ? ins.imm : shadow_regs[ins.src_y];
            item.exp = ref_alu(ins.ctrl.op, ins.ctrl.pass_x, ins.ctrl.x_zero,
                               x_val, y_val, shadow_carry_n);
            // sampled at the next edge, result follows two edges later
            item.edge_no = cycle_cnt + 3;
            // the carry flag is already updated when the next instruction computes
            shadow_carry_n = item.exp.carry_n;
            pend1 = '{valid: 1'b1, idx: ins.dst, data: item.exp.result};
            exp_q.push_back(item);
        end
        instr_strobe = strobe;
        instr        = ins;
    endtask

    task automatic issue(input dp_pkg::instr_t ins);
        step(1'b1, ins);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step(1'b0, '0);
    endtask

    task automatic load_imm(input dp_pkg::reg_idx_t dst, input data_t value);
        issue(make_instr(alu_pkg::OP_B, dst, 2'd0, 2'd0, 1'b1, value));
    endtask

    task automatic reg_op(input alu_pkg::alu_op_e op, input dp_pkg::reg_idx_t dst,
                          input dp_pkg::reg_idx_t sx, input dp_pkg::reg_idx_t sy);
        issue(make_instr(op, dst, sx, sy, 1'b0, 8'h00));
    endtask

    task automatic imm_op(input alu_pkg::alu_op_e op, input dp_pkg::reg_idx_t dst,
                          input dp_pkg::reg_idx_t sx, input data_t imm);
        issue(make_instr(op, dst, sx, 2'd0, 1'b1, imm));
    endtask

    task automatic drain_results;
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 8) begin
            idle_cycles(1);
            waited++;
        end
        idle_cycles(1);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d results never appeared on result_valid", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        drain_results();
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    always @(negedge clk) begin : compare_results
        expect_t item;
        if (arst_n === 1'b1 && result_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("result_valid went high at %0t with no instruction outstanding",
                         $time);
            end else begin
                item = exp_q.pop_front();
                check_value("result", 32'(result), 32'(item.exp.result));
                check_value("carry_n", 32'(carry_n), 32'(item.exp.carry_n));
                check_value("result_edge", cycle_cnt, item.edge_no);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with %0d results outstanding",
                 WATCHDOG_NS, exp_q.size());
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        dp_pkg::instr_t ins;
        int             errs0;
        arst_n         = 1'b0;
        instr_strobe   = 1'b0;
        instr          = '0;
        shadow_carry_n = 1'b1;
        pend1          = '0;
        pend2          = '0;
        for (int i = 0; i < dp_pkg::NUM_REGS; i++) begin
            shadow_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;

        errs0 = errors;
        check_value("result_valid", 32'(result_valid), 32'(0));
        check_value("carry_n", 32'(carry_n), 32'(1));
        reg_op(alu_pkg::OP_A, 2'd0, 2'd0, 2'd0);
        finish_test("reset_state", errs0);

        errs0 = errors;
        for (int i = 0; i < dp_pkg::NUM_REGS; i++) begin
            load_imm(dp_pkg::reg_idx_t'(i), data_t'(8'h11 * (i + 1)));
        end
        idle_cycles(1);
        for (int i = 0; i < dp_pkg::NUM_REGS; i++) begin
            reg_op(alu_pkg::OP_A, dp_pkg::reg_idx_t'(i), dp_pkg::reg_idx_t'(i), 2'd0);
        end
        // a borrow is left pending so the zero row has a carry to clear
        reg_op(alu_pkg::OP_NEG_A, 2'd3, 2'd1, 2'd0);
        reg_op(alu_pkg::OP_ZERO, 2'd3, 2'd1, 2'd2);
        finish_test("immediate_load", errs0);

        errs0 = errors;
        load_imm(2'd0, 8'hFF);
        load_imm(2'd1, 8'h01);
        idle_cycles(1);
        // 0xFF + 0x01 sets the carry and the next add takes it in
        reg_op(alu_pkg::OP_ADD, 2'd2, 2'd0, 2'd1);
        reg_op(alu_pkg::OP_ADD, 2'd3, 2'd1, 2'd1);
        reg_op(alu_pkg::OP_SUB, 2'd2, 2'd1, 2'd0);
        reg_op(alu_pkg::OP_SUB, 2'd3, 2'd0, 2'd1);
        reg_op(alu_pkg::OP_NEG_A, 2'd2, 2'd0, 2'd0);
        imm_op(alu_pkg::OP_NEG_B, 2'd2, 2'd0, 8'h00);
        reg_op(alu_pkg::OP_A_INC, 2'd3, 2'd0, 2'd0);
        imm_op(alu_pkg::OP_B_INC, 2'd3, 2'd0, 8'h7F);
        reg_op(alu_pkg::OP_A_DEC, 2'd2, 2'd1, 2'd0);
        imm_op(alu_pkg::OP_B_DEC, 2'd2, 2'd0, 8'h00);
        finish_test("carry_arithmetic", errs0);

        errs0 = errors;
        load_imm(2'd0, 8'hC8);
        load_imm(2'd1, 8'hFA);
        idle_cycles(1);
        // a carry is left pending so the next rows must clear it
        reg_op(alu_pkg::OP_ADD, 2'd2, 2'd0, 2'd1);
        reg_op(alu_pkg::OP_MUL_HI, 2'd2, 2'd0, 2'd1);
        reg_op(alu_pkg::OP_MUL_LO, 2'd3, 2'd0, 2'd1);
        reg_op(alu_pkg::OP_AND, 2'd2, 2'd0, 2'd1);
        reg_op(alu_pkg::OP_OR, 2'd3, 2'd0, 2'd1);
        finish_test("multiply_logic", errs0);

        errs0 = errors;
        load_imm(2'd0, 8'hC8);
        load_imm(2'd1, 8'hFA);
        idle_cycles(1);
        ins = make_instr(alu_pkg::OP_MUL_LO, 2'd2, 2'd0, 2'd1, 1'b0, 8'h00);
        ins.ctrl.pass_x = 1'b1;
        issue(ins);
        ins = make_instr(alu_pkg::OP_SUB, 2'd3, 2'd1, 2'd0, 1'b0, 8'h00);
        ins.ctrl.pass_x = 1'b1;
        issue(ins);
        ins = make_instr(alu_pkg::OP_A, 2'd2, 2'd0, 2'd1, 1'b0, 8'h00);
        ins.ctrl.x_zero = 1'b1;
        issue(ins);
        reg_op(alu_pkg::OP_ADD, 2'd3, 2'd0, 2'd1);
        ins = make_instr(alu_pkg::OP_ADD, 2'd2, 2'd0, 2'd0, 1'b1, 8'h10);
        ins.ctrl.x_zero = 1'b1;
        issue(ins);
        finish_test("overrides", errs0);

        errs0 = errors;
        for (int n = 0; n < RANDOM_INSTR; n++) begin
            if (($random(seed) & 3) == 0) begin
                idle_cycles(1);
            end
            ins = '0;
            ins.ctrl.op     = op_list[$unsigned($random(seed)) % 15];
            ins.ctrl.pass_x = (($random(seed) & 7) == 0);
            ins.ctrl.x_zero = (($random(seed) & 7) == 0);
            ins.dst         = dp_pkg::reg_idx_t'($random(seed));
            ins.src_x       = dp_pkg::reg_idx_t'($random(seed));
            ins.src_y       = dp_pkg::reg_idx_t'($random(seed));
            ins.y_imm_sel   = (($random(seed) & 3) == 0);
            ins.imm         = data_t'($random(seed));
            issue(ins);
        end
        finish_test("random_stream", errs0);

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results left over at the end of the run", exp_q.size());
        end
        $display("tests passed: %0d, tests failed: %0d, checks: %0d, errors: %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
source/alu_pkg.sv
source/dp_pkg.sv
source/instr_decoder.sv
source/reg_file.sv
source/alu.sv
source/result_writeback.sv
source/alu_datapath.sv
sim/tb_alu_datapath.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_alu_datapath
FILELIST := files.f
OBJ_DIR  := obj_dir
PASS_MSG := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with $(SIM) and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
